// ==== design/cpuDecode_macros.svh ====
`ifndef CPU_DECODE_MACROS_SVH
`define CPU_DECODE_MACROS_SVH

// ==============================
// Datapath widths
// ==============================

// Opcode, operand, accumulator and bank-select nibbles
`define NIBBLE_W 4

// Machine-cycle counter A1..X3
`define CYCLE_W 3

// ==============================
// Execute phases of the machine cycle
// ==============================

`define CYCLE_X1 3'd5  // Temp register load
`define CYCLE_X2 3'd6  // RAM read slot
`define CYCLE_X3 3'd7  // Write-back and flag update

`endif

// ==== design/cpuDecodePkg.sv ====
`include "cpuDecode_macros.svh"

package cpuDecodePkg;

    // ==============================
    // Main opcodes, upper ROM nibble
    // ==============================
    typedef enum logic [`NIBBLE_W-1:0] {
        NOP     = 4'h0,
        JCN     = 4'h1,
        FIM_SRC = 4'h2,  // FIM on even opa, SRC on odd
        FIN_JIN = 4'h3,  // FIN on even opa, JIN on odd
        JUN     = 4'h4,
        JMS     = 4'h5,
        INC     = 4'h6,
        ISZ     = 4'h7,
        ADD     = 4'h8,  // ACC + reg + carry
        SUB     = 4'h9,  // ACC - reg - borrow
        LD      = 4'hA,
        XCH     = 4'hB,
        BBL     = 4'hC,
        LDM     = 4'hD,
        E_      = 4'hE,  // RAM and I/O group
        F_      = 4'hF   // Accumulator group
    } oprE;

    // E group subcodes, taken from opa
    typedef enum logic [`NIBBLE_W-1:0] {
        WRM = 4'h0, WMP = 4'h1, WRR = 4'h2, WPM = 4'h3,
        WR0 = 4'h4, WR1 = 4'h5, WR2 = 4'h6, WR3 = 4'h7,
        SBM = 4'h8, RDM = 4'h9, RDR = 4'hA, ADM = 4'hB,
        RD0 = 4'hC, RD1 = 4'hD, RD2 = 4'hE, RD3 = 4'hF
    } ioSubE;

    // F group subcodes, 0xE and 0xF unused
    typedef enum logic [`NIBBLE_W-1:0] {
        CLB = 4'h0, CLC = 4'h1, IAC = 4'h2, CMC = 4'h3,
        CMA = 4'h4, RAL = 4'h5, RAR = 4'h6, TCC = 4'h7,
        DAC = 4'h8, TCS = 4'h9, STC = 4'hA, DAA = 4'hB,
        KBP = 4'hC, DCL = 4'hD
    } accSubE;

    // ==============================
    // ALU operand source and flag actions
    // ==============================
    typedef enum logic [1:0] {
        SRC_REG  = 2'd0,
        SRC_IMM  = 2'd1,
        SRC_RAM  = 2'd2,
        SRC_NONE = 2'd3   // Idle value of aluSel
    } aluSrcE;

    typedef enum logic [2:0] {
        CARRY_KEEP   = 3'd0,
        CARRY_ALU    = 3'd1,
        CARRY_CLEAR  = 3'd2,
        CARRY_SET    = 3'd3,
        CARRY_INVERT = 3'd4
    } carryUpdE;

    typedef enum logic {
        ZERO_KEEP = 1'b0,
        ZERO_ALU  = 1'b1
    } zeroUpdE;

endpackage

// ==== design/decodeReqIf.sv ====
`timescale 1ns/1ps
`include "cpuDecode_macros.svh"

interface decodeReqIf;
    import cpuDecodePkg::*;

    logic                 aluEnable;
    oprE                  aluOp;
    logic [`NIBBLE_W-1:0] aluSubOp;
    aluSrcE               aluSrc;
    logic                 aluSrcAtX3;   // Source valid at X3 only
    logic                 aluAtX2Only;  // RAM-read class, ALU at X2 with ramRe
    logic                 accWe;
    logic                 regWe;
    logic                 regFromTemp;
    logic                 ramWe;
    logic                 ioWe;
    logic                 ioRe;
    logic                 bankSelWe;
    carryUpdE             carryUpd;
    zeroUpdE              zeroUpd;

    modport producer (
        output aluEnable, aluOp, aluSubOp, aluSrc, aluSrcAtX3, aluAtX2Only,
        output accWe, regWe, regFromTemp, ramWe, ioWe, ioRe, bankSelWe,
        output carryUpd, zeroUpd
    );

    modport consumer (
        input aluEnable, aluOp, aluSubOp, aluSrc, aluSrcAtX3, aluAtX2Only,
        input accWe, regWe, regFromTemp, ramWe, ioWe, ioRe, bankSelWe,
        input carryUpd, zeroUpd
    );

endinterface

// ==== design/baseOpDecoder.sv ====
`timescale 1ns/1ps

module baseOpDecoder (
    input  cpuDecodePkg::oprE opr,
    decodeReqIf.producer      req
);
    import cpuDecodePkg::*;

    always_comb begin
        // Idle request
        req.aluEnable   = 1'b0;
        req.aluOp       = NOP;
        req.aluSubOp    = '0;
        req.aluSrc      = SRC_NONE;
        req.aluSrcAtX3  = 1'b0;
        req.aluAtX2Only = 1'b0;   // RAM reads live in the E group
        req.accWe       = 1'b0;
        req.regWe       = 1'b0;
        req.regFromTemp = 1'b0;
        req.ramWe       = 1'b0;
        req.ioWe        = 1'b0;
        req.ioRe        = 1'b0;
        req.bankSelWe   = 1'b0;
        req.carryUpd    = CARRY_KEEP;
        req.zeroUpd     = ZERO_KEEP;

        case (opr)
            INC: begin
                req.aluEnable  = 1'b1;
                req.aluOp      = opr;
                req.aluSrc     = SRC_REG;
                req.aluSrcAtX3 = 1'b1;
                req.regWe      = 1'b1;   // Result back to the register
                req.carryUpd   = CARRY_ALU;
                req.zeroUpd    = ZERO_ALU;
            end

            ADD, SUB: begin
                req.aluEnable  = 1'b1;
                req.aluOp      = opr;
                req.aluSrc     = SRC_REG;
                req.aluSrcAtX3 = 1'b1;
                req.accWe      = 1'b1;
                req.carryUpd   = CARRY_ALU;
                req.zeroUpd    = ZERO_ALU;
            end

            LD: begin
                req.aluEnable  = 1'b1;
                req.aluOp      = opr;
                req.aluSrc     = SRC_REG;
                req.aluSrcAtX3 = 1'b1;
                req.accWe      = 1'b1;
                req.zeroUpd    = ZERO_ALU;   // Carry untouched
            end

            // Register goes to ACC, old ACC comes back via temp
            XCH: begin
                req.aluSrc      = SRC_REG;
                req.aluSrcAtX3  = 1'b1;
                req.accWe       = 1'b1;
                req.regWe       = 1'b1;
                req.regFromTemp = 1'b1;
            end

            BBL, LDM: begin
                req.aluEnable = 1'b1;
                req.aluOp     = opr;
                req.aluSrc    = SRC_IMM;   // Immediate in every cycle
                req.accWe     = 1'b1;
                if (opr == LDM) begin
                    req.zeroUpd = ZERO_ALU;
                end
            end

            default: ;   // Jumps, FIM/SRC, FIN/JIN, ISZ and E/F groups
        endcase
    end

endmodule

// ==== design/extOpDecoder.sv ====
`timescale 1ns/1ps
`include "cpuDecode_macros.svh"

module extOpDecoder (
    input  cpuDecodePkg::oprE    opr,
    input  logic [`NIBBLE_W-1:0] opa,
    decodeReqIf.producer         req
);
    import cpuDecodePkg::*;

    ioSubE  ioSub;
    accSubE accSub;

    assign ioSub  = ioSubE'(opa);
    assign accSub = accSubE'(opa);

    always_comb begin
        // Idle request
        req.aluEnable   = 1'b0;
        req.aluOp       = NOP;
        req.aluSubOp    = '0;
        req.aluSrc      = SRC_NONE;
        req.aluSrcAtX3  = 1'b0;   // Register-class sources are decoded elsewhere
        req.aluAtX2Only = 1'b0;
        req.accWe       = 1'b0;
        req.regWe       = 1'b0;
        req.regFromTemp = 1'b0;
        req.ramWe       = 1'b0;
        req.ioWe        = 1'b0;
        req.ioRe        = 1'b0;
        req.bankSelWe   = 1'b0;
        req.carryUpd    = CARRY_KEEP;
        req.zeroUpd     = ZERO_KEEP;

        // ==============================
        // RAM and I/O group
        // ==============================
        if (opr == E_) begin
            case (ioSub)
                WRM, WR0, WR1, WR2, WR3: req.ramWe = 1'b1;   // Main or status char
                WMP, WRR:                req.ioWe  = 1'b1;   // RAM port or ROM port
                RDR: begin
                    req.ioRe  = 1'b1;
                    req.accWe = 1'b1;
                end
                SBM, RDM, ADM, RD0, RD1, RD2, RD3: begin
                    req.aluAtX2Only = 1'b1;   // RAM data is on the bus at X2
                    req.aluEnable   = 1'b1;
                    req.aluSrc      = SRC_RAM;
                    req.accWe       = 1'b1;
                    if (ioSub == SBM) begin
                        req.aluOp = SUB;
                    end else if (ioSub == ADM) begin
                        req.aluOp = ADD;
                    end else begin
                        req.aluOp = LD;
                    end
                    if (ioSub == SBM || ioSub == ADM) begin
                        req.carryUpd = CARRY_ALU;
                        req.zeroUpd  = ZERO_ALU;
                    end
                end
                default: ;   // WPM not supported
            endcase
        end

        // ==============================
        // Accumulator group
        // ==============================
        if (opr == F_) begin
            req.aluEnable = 1'b1;
            req.aluOp     = F_;
            req.aluSubOp  = opa;   // ALU picks the operation from the subcode
            case (accSub)
                CLB, TCC, TCS: begin
                    req.accWe    = 1'b1;
                    req.carryUpd = CARRY_CLEAR;
                end
                CLC:           req.carryUpd = CARRY_CLEAR;
                CMC:           req.carryUpd = CARRY_INVERT;
                STC:           req.carryUpd = CARRY_SET;
                CMA, KBP:      req.accWe    = 1'b1;
                RAL, RAR, DAA: begin
                    req.accWe    = 1'b1;
                    req.carryUpd = CARRY_ALU;   // Rotate-out or BCD carry
                end
                IAC, DAC: begin
                    req.accWe    = 1'b1;
                    req.carryUpd = CARRY_ALU;
                    req.zeroUpd  = ZERO_ALU;
                end
                DCL:           req.bankSelWe = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/strobeFlagUnit.sv ====
`timescale 1ns/1ps
`include "cpuDecode_macros.svh"

module strobeFlagUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [`CYCLE_W-1:0]  cycle,
    input  logic [`NIBBLE_W-1:0] opa,
    input  logic                 carryFromAlu,
    input  logic                 zeroFromAlu,
    input  logic                 testFlag,
    input  logic [`NIBBLE_W-1:0] accIn,
    decodeReqIf.consumer         baseReq,
    decodeReqIf.consumer         extReq,
    output logic                 aluEnable,
    output cpuDecodePkg::oprE    aluOp,
    output logic [`NIBBLE_W-1:0] aluSubOp,
    output cpuDecodePkg::aluSrcE aluSel,
    output logic                 accWe,
    output logic                 tempWe,
    output logic                 regWe,
    output logic                 regSrcSel,
    output logic                 ramWe,
    output logic                 ramRe,
    output logic                 ioWe,
    output logic                 ioRe,
    output logic                 bankSelWe,
    output logic [`NIBBLE_W-1:0] bankSelData,
    output logic                 carryFlag,
    output logic                 zeroFlag,
    output logic                 ccOut
);
    import cpuDecodePkg::*;

    logic                 isX1;
    logic                 isX2;
    logic                 isX3;
    logic                 aluReq;
    logic                 aluLive;    // ALU request valid in this phase
    oprE                  aluOpReq;
    logic [`NIBBLE_W-1:0] aluSubOpReq;
    aluSrcE               aluSrcReq;
    logic                 srcAtX3Req;
    logic                 x2OnlyReq;
    carryUpdE             carryUpdReq;
    zeroUpdE              zeroUpdReq;
    aluSrcE               aluSelNext;
    logic                 carryNext;
    logic                 zeroNext;

    assign isX1 = (cycle == `CYCLE_X1);
    assign isX2 = (cycle == `CYCLE_X2);
    assign isX3 = (cycle == `CYCLE_X3);

    // ==============================
    // Request merge
    // ==============================
    assign aluReq      = baseReq.aluEnable | extReq.aluEnable;
    assign x2OnlyReq   = baseReq.aluAtX2Only | extReq.aluAtX2Only;
    assign srcAtX3Req  = baseReq.aluSrcAtX3 | extReq.aluSrcAtX3;
    assign aluOpReq    = baseReq.aluEnable ? baseReq.aluOp    : extReq.aluOp;
    assign aluSubOpReq = baseReq.aluEnable ? baseReq.aluSubOp : extReq.aluSubOp;
    assign aluSrcReq   = (baseReq.aluSrc != SRC_NONE) ? baseReq.aluSrc : extReq.aluSrc;
    assign carryUpdReq = (baseReq.carryUpd != CARRY_KEEP) ? baseReq.carryUpd
                                                          : extReq.carryUpd;
    assign zeroUpdReq  = (baseReq.zeroUpd != ZERO_KEEP) ? baseReq.zeroUpd : extReq.zeroUpd;

    assign aluLive = aluReq && (!x2OnlyReq || isX2);

    always_comb begin
        aluSelNext = SRC_NONE;
        if ((!x2OnlyReq || isX2) && (!srcAtX3Req || isX3)) begin
            aluSelNext = aluSrcReq;
        end
    end

    // Flag actions take effect only at X3
    always_comb begin
        carryNext = carryFlag;
        zeroNext  = zeroFlag;
        if (isX3) begin
            case (carryUpdReq)
                CARRY_ALU:    carryNext = carryFromAlu;
                CARRY_CLEAR:  carryNext = 1'b0;
                CARRY_SET:    carryNext = 1'b1;
                CARRY_INVERT: carryNext = ~carryFlag;
                default: ;
            endcase
            if (zeroUpdReq == ZERO_ALU) begin
                zeroNext = zeroFromAlu;
            end
        end
    end

    // ==============================
    // Strobe and flag registers
    // ==============================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluEnable   <= 1'b0;
            aluOp       <= NOP;
            aluSubOp    <= '0;
            aluSel      <= SRC_REG;
            accWe       <= 1'b0;
            tempWe      <= 1'b0;
            regWe       <= 1'b0;
            regSrcSel   <= 1'b0;
            ramWe       <= 1'b0;
            ramRe       <= 1'b0;
            ioWe        <= 1'b0;
            ioRe        <= 1'b0;
            bankSelWe   <= 1'b0;
            bankSelData <= '0;
            carryFlag   <= 1'b0;
            zeroFlag    <= 1'b0;
        end else begin
            aluEnable   <= aluLive;
            aluOp       <= aluLive ? aluOpReq : NOP;
            aluSubOp    <= aluLive ? aluSubOpReq : '0;
            aluSel      <= aluSelNext;
            tempWe      <= isX1;                          // Temp <- ACC for every opcode
            ramRe       <= isX2 && x2OnlyReq;
            accWe       <= isX3 && (baseReq.accWe | extReq.accWe);
            regWe       <= isX3 && (baseReq.regWe | extReq.regWe);
            regSrcSel   <= isX3 && (baseReq.regFromTemp | extReq.regFromTemp);
            ramWe       <= isX3 && (baseReq.ramWe | extReq.ramWe);
            ioWe        <= isX3 && (baseReq.ioWe | extReq.ioWe);
            ioRe        <= isX3 && (baseReq.ioRe | extReq.ioRe);
            bankSelWe   <= isX3 && (baseReq.bankSelWe | extReq.bankSelWe);
            bankSelData <= (isX3 && (baseReq.bankSelWe | extReq.bankSelWe)) ? accIn : '0;
            carryFlag   <= carryNext;
            zeroFlag    <= zeroNext;
        end
    end

    // Jump condition, opa[3] inverts
    assign ccOut = ((~testFlag & opa[0]) | (carryFlag & opa[1]) | (zeroFlag & opa[2]))
                   ^ opa[3];

endmodule

// ==== design/decoderWithCc.sv ====
`timescale 1ns/1ps
`include "cpuDecode_macros.svh"

module decoderWithCc (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [`NIBBLE_W-1:0] opr,           // Upper ROM nibble
    input  logic [`NIBBLE_W-1:0] opa,           // Lower ROM nibble
    input  logic [`CYCLE_W-1:0]  cycle,         // A1..X3 as 0..7
    input  logic                 carryFromAlu,
    input  logic                 zeroFromAlu,
    input  logic                 testFlag,      // TEST pin
    input  logic [`NIBBLE_W-1:0] accIn,
    output logic                 aluEnable,
    output logic [`NIBBLE_W-1:0] aluOp,
    output logic [`NIBBLE_W-1:0] aluSubOp,
    output logic [1:0]           aluSel,        // 0 reg, 1 imm, 2 RAM, 3 none
    output logic                 accWe,
    output logic                 tempWe,
    output logic                 regWe,
    output logic                 regSrcSel,
    output logic                 ramWe,
    output logic                 ramRe,
    output logic                 ioWe,
    output logic                 ioRe,
    output logic                 bankSelWe,
    output logic [`NIBBLE_W-1:0] bankSelData,
    output logic                 carryFlag,
    output logic                 zeroFlag,
    output logic                 ccOut
);
    import cpuDecodePkg::*;

    oprE oprCode;

    assign oprCode = oprE'(opr);

    decodeReqIf baseReq ();
    decodeReqIf extReq ();

    // Opcodes 0x0..0xD
    baseOpDecoder baseDec (
        .opr (oprCode),
        .req (baseReq)
    );

    // E and F groups
    extOpDecoder extDec (
        .opr (oprCode),
        .opa (opa),
        .req (extReq)
    );

    strobeFlagUnit strobeUnit (
        .clk          (clk),
        .rstN         (rstN),
        .cycle        (cycle),
        .opa          (opa),
        .carryFromAlu (carryFromAlu),
        .zeroFromAlu  (zeroFromAlu),
        .testFlag     (testFlag),
        .accIn        (accIn),
        .baseReq      (baseReq),
        .extReq       (extReq),
        .aluEnable    (aluEnable),
        .aluOp        (aluOp),
        .aluSubOp     (aluSubOp),
        .aluSel       (aluSel),
        .accWe        (accWe),
        .tempWe       (tempWe),
        .regWe        (regWe),
        .regSrcSel    (regSrcSel),
        .ramWe        (ramWe),
        .ramRe        (ramRe),
        .ioWe         (ioWe),
        .ioRe         (ioRe),
        .bankSelWe    (bankSelWe),
        .bankSelData  (bankSelData),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .ccOut        (ccOut)
    );

endmodule

// ==== verif/decoderWithCc_properties.sv ====
`timescale 1ns/1ps

module decoderWithCc_properties (
    input logic       clk,
    input logic       rstN,
    input logic       aluEnable,
    input logic [1:0] aluSel,
    input logic       accWe,
    input logic       tempWe,
    input logic       regWe,
    input logic       regSrcSel,
    input logic       ramWe,
    input logic       ramRe,
    input logic       ioWe,
    input logic       ioRe,
    input logic       bankSelWe
);
    import cpuDecodePkg::*;

    logic anyStrobe;
    int   assertFailCount = 0;   // Read by the testbench top

    assign anyStrobe = aluEnable | accWe | tempWe | regWe | regSrcSel | ramWe | ramRe |
                       ioWe | ioRe | bankSelWe;

    ramExclusive: assert property (@(posedge clk) disable iff (!rstN) !(ramRe && ramWe))
        else begin
            $error("RAM read and write strobes are high together");
            assertFailCount++;
        end

    ramSelHasRead: assert property (@(posedge clk) disable iff (!rstN)
                                    (aluSel == SRC_RAM) |-> ramRe)
        else begin
            $error("ALU selects RAM data without a RAM read");
            assertFailCount++;
        end

    bankNotAcc: assert property (@(posedge clk) disable iff (!rstN) !(bankSelWe && accWe))
        else begin
            $error("Bank select write and accumulator write are high together");
            assertFailCount++;
        end

    // Held reset keeps every strobe quiet
    resetQuiet: assert property (@(posedge clk) (!rstN && $past(!rstN)) |-> !anyStrobe)
        else begin
            $error("A strobe is high while reset is asserted");
            assertFailCount++;
        end

endmodule

// ==== verif/decoderRefModel.svh ====
`ifndef DECODER_REF_MODEL_SVH
`define DECODER_REF_MODEL_SVH

// ==============================
// Expected registered outputs
// ==============================
logic       expAluEnable;
logic [3:0] expAluOp;
logic [3:0] expAluSubOp;
logic [1:0] expAluSel;
logic       expAccWe;
logic       expTempWe;
logic       expRegWe;
logic       expRegSrcSel;
logic       expRamWe;
logic       expRamRe;
logic       expIoWe;
logic       expIoRe;
logic       expBankSelWe;
logic [3:0] expBankSelData;
logic       expCarry;
logic       expZero;

// Carry actions at X3
localparam int actKeep   = 0;
localparam int actAlu    = 1;
localparam int actClear  = 2;
localparam int actSet    = 3;
localparam int actInvert = 4;

function automatic void resetModel();
    expAluEnable   = 1'b0;
    expAluOp       = 4'h0;
    expAluSubOp    = 4'h0;
    expAluSel      = 2'd0;   // Register source out of reset
    expAccWe       = 1'b0;
    expTempWe      = 1'b0;
    expRegWe       = 1'b0;
    expRegSrcSel   = 1'b0;
    expRamWe       = 1'b0;
    expRamRe       = 1'b0;
    expIoWe        = 1'b0;
    expIoRe        = 1'b0;
    expBankSelWe   = 1'b0;
    expBankSelData = 4'h0;
    expCarry       = 1'b0;
    expZero        = 1'b0;
endfunction

// Jump condition from opa, TEST pin and flags
function automatic logic condOut(input logic [3:0] opaVal, input logic testVal,
                                 input logic carryVal, input logic zeroVal);
    logic hit;
    hit = (!testVal && opaVal[0]) || (carryVal && opaVal[1]) || (zeroVal && opaVal[2]);
    return opaVal[3] ? !hit : hit;
endfunction

// One clock edge, from the inputs sampled at that edge
function automatic void stepModel(input logic [3:0] oprVal, input logic [3:0] opaVal,
                                  input logic [2:0] cycVal, input logic carryAlu,
                                  input logic zeroAlu, input logic [3:0] accVal);
    logic       aluReq;
    logic [3:0] opCode;
    logic [3:0] subCode;
    logic [1:0] src;
    logic       srcAtX3;
    logic       ramRead;
    logic       wrAcc;
    logic       wrReg;
    logic       fromTemp;
    logic       wrRam;
    logic       wrIo;
    logic       rdIo;
    logic       wrBank;
    int         carryAct;
    logic       zeroAct;
    logic       phaseOk;
    logic       isX3;

    aluReq   = 1'b0;
    opCode   = 4'h0;
    subCode  = 4'h0;
    src      = 2'd3;   // No operand source
    srcAtX3  = 1'b0;
    ramRead  = 1'b0;
    wrAcc    = 1'b0;
    wrReg    = 1'b0;
    fromTemp = 1'b0;
    wrRam    = 1'b0;
    wrIo     = 1'b0;
    rdIo     = 1'b0;
    wrBank   = 1'b0;
    carryAct = actKeep;
    zeroAct  = 1'b0;

    case (oprVal)
        4'h6, 4'h8, 4'h9, 4'hA: begin   // INC, ADD, SUB, LD
            aluReq   = 1'b1;
            opCode   = oprVal;
            src      = 2'd0;
            srcAtX3  = 1'b1;
            wrReg    = (oprVal == 4'h6);
            wrAcc    = (oprVal != 4'h6);
            carryAct = (oprVal == 4'hA) ? actKeep : actAlu;
            zeroAct  = 1'b1;
        end
        4'hB: begin                     // XCH
            src      = 2'd0;
            srcAtX3  = 1'b1;
            wrAcc    = 1'b1;
            wrReg    = 1'b1;
            fromTemp = 1'b1;
        end
        4'hC, 4'hD: begin               // BBL, LDM
            aluReq  = 1'b1;
            opCode  = oprVal;
            src     = 2'd1;
            wrAcc   = 1'b1;
            zeroAct = (oprVal == 4'hD);
        end
        4'hE: begin
            case (opaVal)
                4'h0, 4'h4, 4'h5, 4'h6, 4'h7: wrRam = 1'b1;
                4'h1, 4'h2:                   wrIo  = 1'b1;
                4'hA: begin                   // RDR
                    rdIo  = 1'b1;
                    wrAcc = 1'b1;
                end
                4'h3: ;                       // WPM does nothing
                default: begin                // SBM, RDM, ADM, RD0..RD3
                    aluReq  = 1'b1;
                    ramRead = 1'b1;
                    src     = 2'd2;
                    wrAcc   = 1'b1;
                    opCode  = (opaVal == 4'h8) ? 4'h9 : ((opaVal == 4'hB) ? 4'h8 : 4'hA);
                    if (opaVal == 4'h8 || opaVal == 4'hB) begin
                        carryAct = actAlu;
                        zeroAct  = 1'b1;
                    end
                end
            endcase
        end
        4'hF: begin
            aluReq  = 1'b1;
            opCode  = 4'hF;
            subCode = opaVal;
            case (opaVal)
                4'h0, 4'h7, 4'h9: begin       // CLB, TCC, TCS
                    wrAcc    = 1'b1;
                    carryAct = actClear;
                end
                4'h1:             carryAct = actClear;
                4'h3:             carryAct = actInvert;
                4'hA:             carryAct = actSet;
                4'h4, 4'hC:       wrAcc    = 1'b1;
                4'h5, 4'h6, 4'hB: begin       // RAL, RAR, DAA
                    wrAcc    = 1'b1;
                    carryAct = actAlu;
                end
                4'h2, 4'h8: begin             // IAC, DAC
                    wrAcc    = 1'b1;
                    carryAct = actAlu;
                    zeroAct  = 1'b1;
                end
                4'hD:             wrBank   = 1'b1;
                default: ;
            endcase
        end
        default: ;
    endcase

    phaseOk = !ramRead || (cycVal == `CYCLE_X2);
    isX3    = (cycVal == `CYCLE_X3);

    expAluEnable   = aluReq && phaseOk;
    expAluOp       = expAluEnable ? opCode : 4'h0;
    expAluSubOp    = expAluEnable ? subCode : 4'h0;
    expAluSel      = (phaseOk && (!srcAtX3 || isX3)) ? src : 2'd3;
    expTempWe      = (cycVal == `CYCLE_X1);
    expRamRe       = ramRead && (cycVal == `CYCLE_X2);
    expAccWe       = isX3 && wrAcc;
    expRegWe       = isX3 && wrReg;
    expRegSrcSel   = isX3 && fromTemp;
    expRamWe       = isX3 && wrRam;
    expIoWe        = isX3 && wrIo;
    expIoRe        = isX3 && rdIo;
    expBankSelWe   = isX3 && wrBank;
    expBankSelData = (isX3 && wrBank) ? accVal : 4'h0;

    if (isX3) begin
        case (carryAct)
            actAlu:    expCarry = carryAlu;
            actClear:  expCarry = 1'b0;
            actSet:    expCarry = 1'b1;
            actInvert: expCarry = !expCarry;
            default: ;
        endcase
        if (zeroAct) begin
            expZero = zeroAlu;
        end
    end
endfunction

`endif

// ==== verif/decoderWithCc_tb.sv ====
`timescale 1ns/1ps
`include "cpuDecode_macros.svh"

module decoderWithCc_tb;

    localparam int resetCycles = 16;
    localparam int phaseCycles = 700;
    localparam int phaseCount  = 6;
    localparam int cycleLimit  = resetCycles + phaseCount * phaseCycles + 200;

    logic       clk;
    logic       rstN;
    logic [3:0] opr;
    logic [3:0] opa;
    logic [2:0] cycle;
    logic       carryFromAlu;
    logic       zeroFromAlu;
    logic       testFlag;
    logic [3:0] accIn;
    logic       aluEnable;
    logic [3:0] aluOp;
    logic [3:0] aluSubOp;
    logic [1:0] aluSel;
    logic       accWe;
    logic       tempWe;
    logic       regWe;
    logic       regSrcSel;
    logic       ramWe;
    logic       ramRe;
    logic       ioWe;
    logic       ioRe;
    logic       bankSelWe;
    logic [3:0] bankSelData;
    logic       carryFlag;
    logic       zeroFlag;
    logic       ccOut;
    int         errorCount = 0;
    int         cycleCount = 0;
    int         seedInit;
    string      phaseName;

    `include "decoderRefModel.svh"

    decoderWithCc decoderWithCc_inst (.*);

    bind strobeFlagUnit decoderWithCc_properties props (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped after the first failure");
    endtask

    task automatic checkValue(input string testName, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (expected !== actual) begin
            errorCount++;
            failRun($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h",
                              testName, expected, actual));
        end
    endtask

    task automatic compareOutputs();
        checkValue({phaseName, " aluEnable"}, expAluEnable, aluEnable);
        checkValue({phaseName, " aluOp"}, expAluOp, aluOp);
        checkValue({phaseName, " aluSubOp"}, expAluSubOp, aluSubOp);
        checkValue({phaseName, " aluSel"}, expAluSel, aluSel);
        checkValue({phaseName, " accWe"}, expAccWe, accWe);
        checkValue({phaseName, " tempWe"}, expTempWe, tempWe);
        checkValue({phaseName, " regWe"}, expRegWe, regWe);
        checkValue({phaseName, " regSrcSel"}, expRegSrcSel, regSrcSel);
        checkValue({phaseName, " ramWe"}, expRamWe, ramWe);
        checkValue({phaseName, " ramRe"}, expRamRe, ramRe);
        checkValue({phaseName, " ioWe"}, expIoWe, ioWe);
        checkValue({phaseName, " ioRe"}, expIoRe, ioRe);
        checkValue({phaseName, " bankSelWe"}, expBankSelWe, bankSelWe);
        checkValue({phaseName, " bankSelData"}, expBankSelData, bankSelData);
        checkValue({phaseName, " carryFlag"}, expCarry, carryFlag);
        checkValue({phaseName, " zeroFlag"}, expZero, zeroFlag);
        checkValue({phaseName, " ccOut"}, condOut(opa, testFlag, expCarry, expZero), ccOut);
        if (decoderWithCc_inst.strobeUnit.props.assertFailCount != 0) begin
            errorCount++;
            failRun({phaseName, ": an assertion on the strobe unit failed"});
        end
    endtask

    // ==============================
    // Random stimulus, one mode per phase
    // ==============================
    task automatic runPhase(input string name, input int mode);
        logic [3:0] nextOpr;
        logic [3:0] nextOpa;
        logic [2:0] nextCycle;
        phaseName = name;
        repeat (phaseCycles) begin
            @(posedge clk);
            stepModel(opr, opa, cycle, carryFromAlu, zeroFromAlu, accIn);
            nextCycle = 3'($urandom_range(0, 7));
            nextOpa   = 4'($urandom);
            case (mode)
                0: nextOpr = 4'($urandom_range(0, 13));   // Main opcodes
                1: nextOpr = 4'hE;
                2: nextOpr = 4'hF;
                3: begin                                  // Mostly DCL
                    nextOpr = 4'hF;
                    if ($urandom_range(0, 1) == 1) begin
                        nextOpa = 4'hD;
                    end
                end
                4: nextOpr = 4'($urandom);
                default: begin                            // Machine cycles in order
                    nextCycle = cycle + 3'd1;
                    nextOpr   = (nextCycle == 3'd0) ? 4'($urandom) : opr;
                    nextOpa   = (nextCycle == 3'd0) ? nextOpa : opa;
                end
            endcase
            opr          <= nextOpr;
            opa          <= nextOpa;
            cycle        <= nextCycle;
            carryFromAlu <= 1'($urandom);
            zeroFromAlu  <= 1'($urandom);
            testFlag     <= 1'($urandom);
            accIn        <= 4'($urandom);
            @(negedge clk);
            compareOutputs();
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        seedInit     = $urandom(74);
        rstN         = 1'b0;
        opr          = 4'h0;
        opa          = 4'h0;
        cycle        = 3'd0;
        carryFromAlu = 1'b0;
        zeroFromAlu  = 1'b0;
        testFlag     = 1'b0;
        accIn        = 4'h0;
        resetModel();
        phaseName = "reset";
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compareOutputs();   // State right after reset release

        runPhase("mainOps", 0);
        runPhase("eGroup", 1);
        runPhase("fGroup", 2);
        runPhase("dclBank", 3);
        runPhase("condMixed", 4);
        runPhase("seqCycles", 5);

        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            failRun("Errors were recorded during the run");
        end
    end

endmodule

// ==== project.f ====
+incdir+design
+incdir+verif
design/cpuDecodePkg.sv
design/decodeReqIf.sv
design/baseOpDecoder.sv
design/extOpDecoder.sv
design/strobeFlagUnit.sv
design/decoderWithCc.sv
verif/decoderWithCc_properties.sv
verif/decoderWithCc_tb.sv

// ==== Bender.yml ====
package:
  name: decoderWithCc

sources:
  - include_dirs:
      - design
    files:
      - design/cpuDecodePkg.sv
      - design/decodeReqIf.sv
      - design/baseOpDecoder.sv
      - design/extOpDecoder.sv
      - design/strobeFlagUnit.sv
      - design/decoderWithCc.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/decoderWithCc_properties.sv
      - verif/decoderWithCc_tb.sv
